//--- source/clk_rst_pkg.sv
//==========================================================
// Shared definitions for the clock/reset control core.
// Holds bus widths, AXI-Lite channel structs, response codes,
// the register map and the domain/lock tables.
//==========================================================
`default_nettype none

package clk_rst_pkg;

   // Bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } aw_chan_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
   } w_chan_t;

   typedef struct packed {
      logic [1:0] resp;
   } b_chan_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } ar_chan_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
   } r_chan_t;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_DECERR = 2'd3;

   //==========================================================
   // Register map
   //==========================================================
   localparam logic [ADDR_W-1:0] REG_BASE = 32'h0005_8000;
   localparam int                REG_SPAN = 4096;
   localparam int                REG_OFS_W = $clog2(REG_SPAN);

   localparam logic [REG_OFS_W-1:0] OFS_DOMAIN_RST = 12'h000;
   localparam logic [REG_OFS_W-1:0] OFS_GLBL_RST   = 12'h004;
   localparam logic [REG_OFS_W-1:0] OFS_LOCK_STAT  = 12'h008;
   localparam logic [REG_OFS_W-1:0] OFS_SCRATCH    = 12'h00C;

   // Domains and locks
   localparam int NUM_DOMAINS = 10;
   localparam int NUM_LOCKS   = 4;

   localparam int D_MAIN    = 0;
   localparam int D_A1      = 1;
   localparam int D_A2      = 2;
   localparam int D_A3      = 3;
   localparam int D_B0      = 4;
   localparam int D_B1      = 5;
   localparam int D_C0      = 6;
   localparam int D_C1      = 7;
   localparam int D_HBM_REF = 8;
   localparam int D_HBM_AXI = 9;

   localparam int LOCK_A   = 0;
   localparam int LOCK_B   = 1;
   localparam int LOCK_C   = 2;
   localparam int LOCK_HBM = 3;

   typedef logic [NUM_DOMAINS-1:0] domain_vec_t;
   typedef logic [NUM_LOCKS-1:0]   lock_vec_t;

   // Domains held in reset by a missing lock
   function automatic domain_vec_t lock_hold(lock_vec_t lock);
      domain_vec_t hold;
      hold            = '0;
      hold[D_MAIN]    = 1'b0;
      hold[D_A1]      = ~lock[LOCK_A];
      hold[D_A2]      = ~lock[LOCK_A];
      hold[D_A3]      = ~lock[LOCK_A];
      hold[D_B0]      = ~lock[LOCK_B];
      hold[D_B1]      = ~lock[LOCK_B];
      hold[D_C0]      = ~lock[LOCK_C];
      hold[D_C1]      = ~lock[LOCK_C];
      // HBM reference clock comes straight from the shell
      hold[D_HBM_REF] = 1'b0;
      hold[D_HBM_AXI] = ~lock[LOCK_HBM];
      return hold;
   endfunction

endpackage

`default_nettype wire

//--- source/axil_chan_slice.sv
//==========================================================
// One-entry valid/ready register slice for a single
// AXI-Lite channel. The payload type is a parameter.
//==========================================================
`timescale 1ns/10ps
`default_nettype none

module axil_chan_slice #(
   parameter type chan_t = logic
) (
   input  wire logic i_clk_main_a0,
   input  wire logic i_arst_n,
   // Upstream side
   input  wire chan_t i_data,
   input  wire logic  i_valid,
   output logic       o_ready,
   // Downstream side
   output chan_t      o_data,
   output logic       o_valid,
   input  wire logic  i_ready
);

   logic full_q;

   // Take a new entry when empty or when the held one leaves now
   assign o_ready = ~full_q | i_ready;
   assign o_valid = full_q;

   always_ff @(posedge i_clk_main_a0 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         full_q <= 1'b0;
      end else if (o_ready) begin
         full_q <= i_valid;
      end
   end

   always_ff @(posedge i_clk_main_a0) begin
      if (o_ready && i_valid) begin
         o_data <= i_data;
      end
   end

   // Stalled output keeps its entry
   a_hold_stable : assert property (
      @(posedge i_clk_main_a0) disable iff (!i_arst_n)
      (o_valid && !i_ready) |=> (o_valid && $stable(o_data))
   );

endmodule

`default_nettype wire

//--- source/axil_region_decode.sv
//==========================================================
// AXI-Lite region decoder. Pairs AW with W, strobes the
// register block for register-region hits and answers all
// other addresses with a decode error.
//==========================================================
`timescale 1ns/10ps
`default_nettype none

module axil_region_decode (
   input  wire logic                  i_clk_main_a0,
   input  wire logic                  i_arst_n,
   // Write request
   input  wire clk_rst_pkg::aw_chan_t i_aw,
   input  wire logic                  i_aw_valid,
   output logic                       o_aw_ready,
   input  wire clk_rst_pkg::w_chan_t  i_w,
   input  wire logic                  i_w_valid,
   output logic                       o_w_ready,
   // Write response
   output clk_rst_pkg::b_chan_t       o_b,
   output logic                       o_b_valid,
   input  wire logic                  i_b_ready,
   // Read request and response
   input  wire clk_rst_pkg::ar_chan_t i_ar,
   input  wire logic                  i_ar_valid,
   output logic                       o_ar_ready,
   output clk_rst_pkg::r_chan_t       o_r,
   output logic                       o_r_valid,
   input  wire logic                  i_r_ready,
   // Register block port
   output logic                                  o_reg_wr,
   output logic                                  o_reg_rd,
   output logic [clk_rst_pkg::REG_OFS_W-1:0]     o_reg_ofs,
   output logic [clk_rst_pkg::DATA_W-1:0]        o_reg_wdata,
   output logic [clk_rst_pkg::STRB_W-1:0]        o_reg_wstrb,
   input  wire logic [clk_rst_pkg::DATA_W-1:0]   i_reg_rdata
);

   logic wr_go;
   logic rd_go;
   logic wr_hit;
   logic rd_hit;

   // Region match on the page bits above the offset
   assign wr_hit = i_aw.addr[clk_rst_pkg::ADDR_W-1:clk_rst_pkg::REG_OFS_W] ==
                   clk_rst_pkg::REG_BASE[clk_rst_pkg::ADDR_W-1:clk_rst_pkg::REG_OFS_W];
   assign rd_hit = i_ar.addr[clk_rst_pkg::ADDR_W-1:clk_rst_pkg::REG_OFS_W] ==
                   clk_rst_pkg::REG_BASE[clk_rst_pkg::ADDR_W-1:clk_rst_pkg::REG_OFS_W];

   // Writes win the register port and reads wait a cycle
   assign wr_go = i_aw_valid & i_w_valid & ~o_b_valid;
   assign rd_go = i_ar_valid & ~o_r_valid & ~wr_go;

   assign o_aw_ready = wr_go;
   assign o_w_ready  = wr_go;
   assign o_ar_ready = rd_go;

   assign o_reg_wr    = wr_go & wr_hit;
   assign o_reg_rd    = rd_go & rd_hit;
   assign o_reg_ofs   = wr_go ? i_aw.addr[clk_rst_pkg::REG_OFS_W-1:0]
                              : i_ar.addr[clk_rst_pkg::REG_OFS_W-1:0];
   assign o_reg_wdata = i_w.data;
   assign o_reg_wstrb = i_w.strb;

   //==========================================================
   // Response registers
   //==========================================================
   always_ff @(posedge i_clk_main_a0 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_b_valid <= 1'b0;
         o_r_valid <= 1'b0;
      end else begin
         if (wr_go) begin
            o_b_valid <= 1'b1;
         end else if (i_b_ready) begin
            o_b_valid <= 1'b0;
         end
         if (rd_go) begin
            o_r_valid <= 1'b1;
         end else if (i_r_ready) begin
            o_r_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge i_clk_main_a0) begin
      if (wr_go) begin
         o_b.resp <= wr_hit ? clk_rst_pkg::RESP_OKAY : clk_rst_pkg::RESP_DECERR;
      end
      if (rd_go) begin
         o_r.data <= rd_hit ? i_reg_rdata : '0;
         o_r.resp <= rd_hit ? clk_rst_pkg::RESP_OKAY : clk_rst_pkg::RESP_DECERR;
      end
   end

   // Write address waiting for its data stays put until joined
   a_aw_hold : assert property (
      @(posedge i_clk_main_a0) disable iff (!i_arst_n)
      (i_aw_valid && !o_aw_ready) |=> (i_aw_valid && $stable(i_aw))
   );

endmodule

`default_nettype wire

//--- source/clk_rst_regs.sv
//==========================================================
// Control registers for the reset domains. Combines the
// domain, global and lock state into one active-low reset
// request per domain.
//==========================================================
`timescale 1ns/10ps
`default_nettype none

module clk_rst_regs (
   input  wire logic                                i_clk_main_a0,
   input  wire logic                                i_arst_n,
   // Register port from the decoder
   input  wire logic                                i_reg_wr,
   input  wire logic                                i_reg_rd,
   input  wire logic [clk_rst_pkg::REG_OFS_W-1:0]   i_reg_ofs,
   input  wire logic [clk_rst_pkg::DATA_W-1:0]      i_reg_wdata,
   input  wire logic [clk_rst_pkg::STRB_W-1:0]      i_reg_wstrb,
   output logic [clk_rst_pkg::DATA_W-1:0]           o_reg_rdata,
   // Clock generator locks
   input  wire clk_rst_pkg::lock_vec_t              i_mmcm_lock,
   output clk_rst_pkg::domain_vec_t                 o_rst_req_n
);

   clk_rst_pkg::domain_vec_t        domain_rst_q;
   logic                            glbl_rst_q;
   logic [clk_rst_pkg::DATA_W-1:0]  scratch_q;
   clk_rst_pkg::lock_vec_t          lock_meta_q;
   clk_rst_pkg::lock_vec_t          lock_q;

   //==========================================================
   // Register writes
   //==========================================================
   always_ff @(posedge i_clk_main_a0 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         domain_rst_q <= '0;
         glbl_rst_q   <= 1'b0;
         scratch_q    <= '0;
      end else if (i_reg_wr) begin
         case (i_reg_ofs)
            clk_rst_pkg::OFS_DOMAIN_RST: begin
               if (i_reg_wstrb[0]) begin
                  domain_rst_q[7:0] <= i_reg_wdata[7:0];
               end
               if (i_reg_wstrb[1]) begin
                  domain_rst_q[clk_rst_pkg::NUM_DOMAINS-1:8] <=
                     i_reg_wdata[clk_rst_pkg::NUM_DOMAINS-1:8];
               end
            end
            clk_rst_pkg::OFS_GLBL_RST: begin
               if (i_reg_wstrb[0]) begin
                  glbl_rst_q <= i_reg_wdata[0];
               end
            end
            clk_rst_pkg::OFS_SCRATCH: begin
               for (int b = 0; b < clk_rst_pkg::STRB_W; b++) begin
                  if (i_reg_wstrb[b]) begin
                     scratch_q[8*b +: 8] <= i_reg_wdata[8*b +: 8];
                  end
               end
            end
            // Lock status is read-only, other offsets ignored
            default: begin
            end
         endcase
      end
   end

   // Read mux, zero outside a read cycle
   always_comb begin
      o_reg_rdata = '0;
      if (i_reg_rd) begin
         case (i_reg_ofs)
            clk_rst_pkg::OFS_DOMAIN_RST: begin
               o_reg_rdata[clk_rst_pkg::NUM_DOMAINS-1:0] = domain_rst_q;
            end
            clk_rst_pkg::OFS_GLBL_RST: begin
               o_reg_rdata[0] = glbl_rst_q;
            end
            clk_rst_pkg::OFS_LOCK_STAT: begin
               o_reg_rdata[clk_rst_pkg::NUM_LOCKS-1:0] = lock_q;
            end
            clk_rst_pkg::OFS_SCRATCH: begin
               o_reg_rdata = scratch_q;
            end
            default: begin
            end
         endcase
      end
   end

   //==========================================================
   // Lock sampling and reset requests
   //==========================================================
   // Locks come from other clock generators, two flops deep
   always_ff @(posedge i_clk_main_a0 or negedge i_arst_n) begin
      if (!i_arst_n) begin
         lock_meta_q <= '0;
         lock_q      <= '0;
      end else begin
         lock_meta_q <= i_mmcm_lock;
         lock_q      <= lock_meta_q;
      end
   end

   assign o_rst_req_n = ~(domain_rst_q |
                          {clk_rst_pkg::NUM_DOMAINS{glbl_rst_q}} |
                          clk_rst_pkg::lock_hold(lock_q));

endmodule

`default_nettype wire

//--- source/rst_sync.sv
//==========================================================
// Reset synchronizer. Asserts at once on either reset input
// and releases SYNC_STAGES clocks after both are high.
//==========================================================
`timescale 1ns/10ps
`default_nettype none

module rst_sync #(
   parameter int SYNC_STAGES = 2
) (
   input  wire logic i_clk_main_a0,
   input  wire logic i_arst_n,
   input  wire logic i_rst_req_n,
   output logic      o_rst_n
);

   logic                   clr_n;
   logic [SYNC_STAGES-1:0] chain_q;

   // Either source clears the chain asynchronously
   assign clr_n = i_arst_n & i_rst_req_n;

   always_ff @(posedge i_clk_main_a0 or negedge clr_n) begin
      if (!clr_n) begin
         chain_q <= '0;
      end else begin
         chain_q <= (chain_q << 1) | SYNC_STAGES'(1);
      end
   end

   assign o_rst_n = chain_q[SYNC_STAGES-1];

   a_no_early_release : assert property (
      @(posedge i_clk_main_a0) disable iff (!i_arst_n)
      $rose(o_rst_n) |-> i_rst_req_n
   );

endmodule

`default_nettype wire

//--- source/clk_rst_top.sv
//==========================================================
// Clock/reset control core top level. AXI-Lite control port
// through channel slices to the decoder and register block,
// then one reset synchronizer per domain.
//==========================================================
`timescale 1ns/10ps
`default_nettype none

module clk_rst_top #(
   parameter int SYNC_STAGES = 2
) (
   input  wire logic                   i_clk_main_a0,
   input  wire logic                   i_arst_n,
   // AXI-Lite control port
   input  wire clk_rst_pkg::aw_chan_t  i_aw,
   input  wire logic                   i_aw_valid,
   output logic                        o_aw_ready,
   input  wire clk_rst_pkg::w_chan_t   i_w,
   input  wire logic                   i_w_valid,
   output logic                        o_w_ready,
   output clk_rst_pkg::b_chan_t        o_b,
   output logic                        o_b_valid,
   input  wire logic                   i_b_ready,
   input  wire clk_rst_pkg::ar_chan_t  i_ar,
   input  wire logic                   i_ar_valid,
   output logic                        o_ar_ready,
   output clk_rst_pkg::r_chan_t        o_r,
   output logic                        o_r_valid,
   input  wire logic                   i_r_ready,
   // Locks and domain resets
   input  wire clk_rst_pkg::lock_vec_t i_mmcm_lock,
   output clk_rst_pkg::domain_vec_t    o_domain_rst_n
);

   clk_rst_pkg::aw_chan_t aw_q;
   logic                  aw_q_valid, aw_q_ready;
   clk_rst_pkg::w_chan_t  w_q;
   logic                  w_q_valid, w_q_ready;
   clk_rst_pkg::ar_chan_t ar_q;
   logic                  ar_q_valid, ar_q_ready;
   clk_rst_pkg::b_chan_t  b_d;
   logic                  b_d_valid, b_d_ready;
   clk_rst_pkg::r_chan_t  r_d;
   logic                  r_d_valid, r_d_ready;

   logic                                reg_wr;
   logic                                reg_rd;
   logic [clk_rst_pkg::REG_OFS_W-1:0]   reg_ofs;
   logic [clk_rst_pkg::DATA_W-1:0]      reg_wdata;
   logic [clk_rst_pkg::STRB_W-1:0]      reg_wstrb;
   logic [clk_rst_pkg::DATA_W-1:0]      reg_rdata;
   clk_rst_pkg::domain_vec_t            rst_req_n;

   //==========================================================
   // Channel slices
   //==========================================================
   axil_chan_slice #(.chan_t(clk_rst_pkg::aw_chan_t)) u_aw_slice (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n (i_arst_n),
      .i_data (i_aw), .i_valid (i_aw_valid), .o_ready (o_aw_ready),
      .o_data (aw_q), .o_valid (aw_q_valid), .i_ready (aw_q_ready)
   );

   axil_chan_slice #(.chan_t(clk_rst_pkg::w_chan_t)) u_w_slice (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n (i_arst_n),
      .i_data (i_w), .i_valid (i_w_valid), .o_ready (o_w_ready),
      .o_data (w_q), .o_valid (w_q_valid), .i_ready (w_q_ready)
   );

   axil_chan_slice #(.chan_t(clk_rst_pkg::ar_chan_t)) u_ar_slice (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n (i_arst_n),
      .i_data (i_ar), .i_valid (i_ar_valid), .o_ready (o_ar_ready),
      .o_data (ar_q), .o_valid (ar_q_valid), .i_ready (ar_q_ready)
   );

   axil_chan_slice #(.chan_t(clk_rst_pkg::b_chan_t)) u_b_slice (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n (i_arst_n),
      .i_data (b_d), .i_valid (b_d_valid), .o_ready (b_d_ready),
      .o_data (o_b), .o_valid (o_b_valid), .i_ready (i_b_ready)
   );

   axil_chan_slice #(.chan_t(clk_rst_pkg::r_chan_t)) u_r_slice (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n (i_arst_n),
      .i_data (r_d), .i_valid (r_d_valid), .o_ready (r_d_ready),
      .o_data (o_r), .o_valid (o_r_valid), .i_ready (i_r_ready)
   );

   axil_region_decode u_region_decode (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n   (i_arst_n),
      .i_aw          (aw_q),          .i_aw_valid (aw_q_valid), .o_aw_ready (aw_q_ready),
      .i_w           (w_q),           .i_w_valid  (w_q_valid),  .o_w_ready  (w_q_ready),
      .o_b           (b_d),           .o_b_valid  (b_d_valid),  .i_b_ready  (b_d_ready),
      .i_ar          (ar_q),          .i_ar_valid (ar_q_valid), .o_ar_ready (ar_q_ready),
      .o_r           (r_d),           .o_r_valid  (r_d_valid),  .i_r_ready  (r_d_ready),
      .o_reg_wr      (reg_wr),        .o_reg_rd   (reg_rd),     .o_reg_ofs  (reg_ofs),
      .o_reg_wdata   (reg_wdata),     .o_reg_wstrb (reg_wstrb), .i_reg_rdata (reg_rdata)
   );

   clk_rst_regs u_clk_rst_regs (
      .i_clk_main_a0 (i_clk_main_a0), .i_arst_n    (i_arst_n),
      .i_reg_wr      (reg_wr),        .i_reg_rd    (reg_rd),
      .i_reg_ofs     (reg_ofs),       .i_reg_wdata (reg_wdata),
      .i_reg_wstrb   (reg_wstrb),     .o_reg_rdata (reg_rdata),
      .i_mmcm_lock   (i_mmcm_lock),   .o_rst_req_n (rst_req_n)
   );

   // One synchronizer per reset domain
   for (genvar d = 0; d < clk_rst_pkg::NUM_DOMAINS; d++) begin : g_rst_sync
      rst_sync #(.SYNC_STAGES(SYNC_STAGES)) u_rst_sync (
         .i_clk_main_a0 (i_clk_main_a0),
         .i_arst_n      (i_arst_n),
         .i_rst_req_n   (rst_req_n[d]),
         .o_rst_n       (o_domain_rst_n[d])
      );
   end

endmodule

`default_nettype wire

//--- tests/tb_clk_rst_top.sv
//==========================================================
// Testbench for the clock/reset control core. Drives the
// AXI-Lite port through bus tasks, models the register map
// and checks responses and domain resets against the model.
//==========================================================
`timescale 1ns/10ps
`default_nettype none

module tb_clk_rst_top;

   localparam int CLK_PERIOD  = 40;
   localparam int SYNC_STAGES = 2;
   localparam int N_SCRATCH   = 16;
   localparam int N_BP        = 16;
   // Transactions over all tests set the watchdog limit
   localparam int NUM_TXN     = 2 * N_SCRATCH + 2 * N_BP + 20;

   logic                      clk;
   logic                      arst_n;
   clk_rst_pkg::aw_chan_t     aw;
   logic                      aw_valid;
   logic                      aw_ready;
   clk_rst_pkg::w_chan_t      w;
   logic                      w_valid;
   logic                      w_ready;
   clk_rst_pkg::b_chan_t      b;
   logic                      b_valid;
   logic                      b_ready;
   clk_rst_pkg::ar_chan_t     ar;
   logic                      ar_valid;
   logic                      ar_ready;
   clk_rst_pkg::r_chan_t      r;
   logic                      r_valid;
   logic                      r_ready;
   clk_rst_pkg::lock_vec_t    lock;
   clk_rst_pkg::domain_vec_t  domain_rst_n;

   // Register model
   logic [9:0]                m_domain;
   logic                      m_glbl;
   logic [31:0]               m_scratch;
   logic [3:0]                m_lock;

   clk_rst_pkg::b_chan_t      exp_b_q[$];
   clk_rst_pkg::r_chan_t      exp_r_q[$];
   clk_rst_pkg::b_chan_t      exp_b;
   clk_rst_pkg::r_chan_t      exp_r;

   integer seed = 96384;
   int     err_count;
   int     check_count;
   int     test_count;
   int     test_err_start;
   int     n_wr;
   int     n_rd;
   int     n_b;
   int     n_r;
   logic   bp_mode;

   clk_rst_top #(.SYNC_STAGES(SYNC_STAGES)) u_clk_rst_top (
      .i_clk_main_a0 (clk),      .i_arst_n    (arst_n),
      .i_aw          (aw),       .i_aw_valid  (aw_valid), .o_aw_ready (aw_ready),
      .i_w           (w),        .i_w_valid   (w_valid),  .o_w_ready  (w_ready),
      .o_b           (b),        .o_b_valid   (b_valid),  .i_b_ready  (b_ready),
      .i_ar          (ar),       .i_ar_valid  (ar_valid), .o_ar_ready (ar_ready),
      .o_r           (r),        .o_r_valid   (r_valid),  .i_r_ready  (r_ready),
      .i_mmcm_lock   (lock),     .o_domain_rst_n (domain_rst_n)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //==========================================================
   // Reference model
   //==========================================================
   function automatic logic addr_hit(input logic [31:0] addr);
      return addr[31:12] == 20'h00058;
   endfunction

   function automatic clk_rst_pkg::r_chan_t exp_read(input logic [31:0] addr);
      clk_rst_pkg::r_chan_t e;
      e.data = '0;
      e.resp = clk_rst_pkg::RESP_DECERR;
      if (addr_hit(addr)) begin
         e.resp = clk_rst_pkg::RESP_OKAY;
         case (addr[11:0])
            clk_rst_pkg::OFS_DOMAIN_RST: e.data[9:0] = m_domain;
            clk_rst_pkg::OFS_GLBL_RST:   e.data[0]   = m_glbl;
            clk_rst_pkg::OFS_LOCK_STAT:  e.data[3:0] = m_lock;
            clk_rst_pkg::OFS_SCRATCH:    e.data      = m_scratch;
            default: begin
            end
         endcase
      end
      return e;
   endfunction

   function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
      if (addr_hit(addr)) begin
         case (addr[11:0])
            clk_rst_pkg::OFS_DOMAIN_RST: begin
               if (strb[0]) m_domain[7:0] = data[7:0];
               if (strb[1]) m_domain[9:8] = data[9:8];
            end
            clk_rst_pkg::OFS_GLBL_RST: begin
               if (strb[0]) m_glbl = data[0];
            end
            clk_rst_pkg::OFS_SCRATCH: begin
               for (int i = 0; i < 4; i++) begin
                  if (strb[i]) m_scratch[8*i +: 8] = data[8*i +: 8];
               end
            end
            default: begin
            end
         endcase
      end
   endfunction

   // Released when neither register bit holds the domain and its lock is up
   function automatic logic [9:0] exp_rst_n();
      logic [9:0] v;
      logic       lk;
      for (int d = 0; d < 10; d++) begin
         case (d)
            1, 2, 3: lk = m_lock[0];
            4, 5:    lk = m_lock[1];
            6, 7:    lk = m_lock[2];
            9:       lk = m_lock[3];
            default: lk = 1'b1;
         endcase
         v[d] = ~m_domain[d] & ~m_glbl & lk;
      end
      return v;
   endfunction

   //==========================================================
   // Checks and response comparison
   //==========================================================
   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("ERR time=%0t signal=%s got=0x%0h exp=0x%0h", $time, name, got, exp);
         err_count++;
      end
   endtask

   always @(posedge clk) begin
      if (b_valid && b_ready) begin
         n_b++;
         if (exp_b_q.size() == 0) begin
            $display("Write response arrived with no write outstanding at %0t", $time);
            err_count++;
         end else begin
            exp_b = exp_b_q.pop_front();
            check_val("o_b.resp", b.resp, exp_b.resp);
         end
      end
      if (r_valid && r_ready) begin
         n_r++;
         if (exp_r_q.size() == 0) begin
            $display("Read response arrived with no read outstanding at %0t", $time);
            err_count++;
         end else begin
            exp_r = exp_r_q.pop_front();
            check_val("o_r.data", r.data, exp_r.data);
            check_val("o_r.resp", r.resp, exp_r.resp);
         end
      end
   end

   //==========================================================
   // Bus tasks
   //==========================================================
   task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
      clk_rst_pkg::b_chan_t e;
      logic                 done;
      e.resp = addr_hit(addr) ? clk_rst_pkg::RESP_OKAY : clk_rst_pkg::RESP_DECERR;
      exp_b_q.push_back(e);
      model_write(addr, data, strb);
      n_wr++;
      @(posedge clk);
      aw.addr  <= addr;
      aw_valid <= 1'b1;
      w.data   <= data;
      w.strb   <= strb;
      w_valid  <= 1'b1;
      b_ready  <= bp_mode ? (($random(seed) & 3) == 0) : 1'b1;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         if (aw_valid && aw_ready) aw_valid <= 1'b0;
         if (w_valid && w_ready) w_valid <= 1'b0;
         if (b_valid && b_ready) done = 1'b1;
         b_ready <= done ? 1'b0 : (bp_mode ? (($random(seed) & 3) == 0) : 1'b1);
      end
   endtask

   task automatic do_read(input logic [31:0] addr);
      logic done;
      exp_r_q.push_back(exp_read(addr));
      n_rd++;
      @(posedge clk);
      ar.addr  <= addr;
      ar_valid <= 1'b1;
      r_ready  <= bp_mode ? (($random(seed) & 3) == 0) : 1'b1;
      done = 1'b0;
      while (!done) begin
         @(posedge clk);
         if (ar_valid && ar_ready) ar_valid <= 1'b0;
         if (r_valid && r_ready) done = 1'b1;
         r_ready <= done ? 1'b0 : (bp_mode ? (($random(seed) & 3) == 0) : 1'b1);
      end
   endtask

   task automatic check_rst();
      repeat (SYNC_STAGES + 4) @(posedge clk);
      check_val("o_domain_rst_n", domain_rst_n, exp_rst_n());
   endtask

   task automatic start_test();
      test_err_start = err_count;
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("test %0d %s errors=%0d", test_count, name, err_count - test_err_start);
   endtask

   //==========================================================
   // Watchdog
   //==========================================================
   initial begin
      #(NUM_TXN * 50 * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, a transaction never completed",
               NUM_TXN * 50);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   //==========================================================
   // Test sequence
   //==========================================================
   initial begin
      logic [31:0] data;
      logic [3:0]  strb;
      logic [31:0] addr;
      clk      = 1'b0;
      arst_n   = 1'b0;
      aw       = '0;
      aw_valid = 1'b0;
      w        = '0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      ar       = '0;
      ar_valid = 1'b0;
      r_ready  = 1'b0;
      lock     = 4'hF;
      bp_mode  = 1'b0;
      m_domain = '0;
      m_glbl   = 1'b0;
      m_scratch = '0;
      m_lock   = 4'hF;

      // All domains held during reset and released after it
      start_test();
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         check_val("o_domain_rst_n", domain_rst_n, 32'h0);
      end
      arst_n <= 1'b1;
      check_rst();
      end_test("reset release");

      // Byte-merged scratch writes
      start_test();
      for (int i = 0; i < N_SCRATCH; i++) begin
         data = $random(seed);
         strb = $random(seed);
         do_write(32'h0005_800C, data, strb);
         do_read(32'h0005_800C);
      end
      end_test("scratch strobes");

      // Per-domain and global reset bits
      start_test();
      do_write(32'h0005_8000, 32'h0000_02A5, 4'b0011);
      do_read(32'h0005_8000);
      check_rst();
      do_write(32'h0005_8004, 32'h1, 4'b0001);
      check_rst();
      do_write(32'h0005_8004, 32'h0, 4'b0001);
      do_read(32'h0005_8004);
      check_rst();
      do_write(32'h0005_8000, 32'h0, 4'b0011);
      check_rst();
      end_test("domain and global");

      // One lock dropped at a time
      start_test();
      for (int l = 0; l < 4; l++) begin
         @(posedge clk);
         lock <= 4'hF & ~(4'b0001 << l);
         m_lock = 4'hF & ~(4'b0001 << l);
         check_rst();
         do_read(32'h0005_8008);
      end
      @(posedge clk);
      lock <= 4'hF;
      m_lock = 4'hF;
      check_rst();
      do_read(32'h0005_8008);
      end_test("lock mapping");

      // Addresses outside the register region
      start_test();
      do_write(32'h0005_000C, 32'hDEAD_BEEF, 4'hF);
      do_write(32'h0005_400C, 32'hCAFE_F00D, 4'hF);
      do_read(32'h0005_0000);
      do_read(32'h0005_4000);
      do_read(32'h0005_400C);
      do_read(32'h0005_8000);
      do_read(32'h0005_8004);
      do_read(32'h0005_8008);
      do_read(32'h0005_800C);
      end_test("decode error");

      // Random response back-pressure
      start_test();
      bp_mode = 1'b1;
      for (int i = 0; i < N_BP; i++) begin
         data = $random(seed);
         strb = $random(seed);
         addr = (i % 4 == 3) ? 32'h0005_400C : 32'h0005_800C;
         do_write(addr, data, strb);
         do_read(addr);
      end
      bp_mode = 1'b0;
      // Both ready lines open so a duplicate response would transfer
      @(posedge clk);
      b_ready <= 1'b1;
      r_ready <= 1'b1;
      repeat (8) @(posedge clk);
      b_ready <= 1'b0;
      r_ready <= 1'b0;
      check_val("b transfer count", n_b, n_wr);
      check_val("r transfer count", n_r, n_rd);
      end_test("back-pressure");

      $display("tests=%0d checks=%0d errors=%0d", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- clk_rst_top.f
source/clk_rst_pkg.sv
source/axil_chan_slice.sv
source/axil_region_decode.sv
source/clk_rst_regs.sv
source/rst_sync.sv
source/clk_rst_top.sv
tests/tb_clk_rst_top.sv

//--- Bender.yml
package:
  name: clk_rst_top

sources:
  - source/clk_rst_pkg.sv
  - source/axil_chan_slice.sv
  - source/axil_region_decode.sv
  - source/clk_rst_regs.sv
  - source/rst_sync.sv
  - source/clk_rst_top.sv
  - target: test
    files:
      - tests/tb_clk_rst_top.sv
